/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  localparam int data_width = 8;   // bits per character
  localparam int oversample = 16;  // ticks per bit
  localparam int div_width  = 16;

  // divisor after reset, one tick every 4 clocks
  localparam logic [div_width-1:0] div_reset = 16'd3;

  localparam int phase_width    = $clog2(oversample);
  localparam int bit_idx_width  = $clog2(data_width);
  localparam int data_cnt_width = phase_width + bit_idx_width;  // ticks over all data bits

  typedef enum logic [0:0] {
    cfg_div  = 1'b0,
    cfg_ctrl = 1'b1   // bit 0 is loopback
  } cfg_addr_t;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    cfg_addr_t            addr;
    logic [div_width-1:0] wdata;
  } cfg_cmd_t;

  typedef struct packed {
    logic [div_width-1:0] divisor;
    logic                 loopback;
  } cfg_t;

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;
  typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  frame_err;  // stop bit seen low
  } rx_byte_t;

endpackage

`default_nettype wire

/* src/uart_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cfg_regs (
  input  logic                           clk,
  input  logic                           reset,
  input  uart_pkg::cfg_cmd_t             cmd,
  output logic [uart_pkg::div_width-1:0] rdata,
  output uart_pkg::cfg_t                 cfg,
  output logic                           div_load
);
  import uart_pkg::*;

  logic wr_en;
  logic rd_en;

  assign wr_en = cmd.valid && cmd.write;
  assign rd_en = cmd.valid && !cmd.write;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cfg.divisor  <= div_reset;
      cfg.loopback <= 1'b0;
      div_load     <= 1'b0;
    end else begin
      div_load <= 1'b0;
      if (wr_en) begin
        case (cmd.addr)
          cfg_div: begin
            cfg.divisor <= cmd.wdata;
            div_load    <= 1'b1;  // restart baud counter
          end
          cfg_ctrl: cfg.loopback <= cmd.wdata[0];
        endcase
      end
    end
  end

  // readback lands one cycle after the read command
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= (cmd.addr == cfg_div) ? cfg.divisor : {{(div_width-1){1'b0}}, cfg.loopback};
    end
  end

endmodule

`default_nettype wire

/* src/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [uart_pkg::div_width-1:0] divisor,
  input  logic                           div_load,
  output logic                           tick
);
  import uart_pkg::*;

  logic [div_width-1:0] count;

  // tick once every divisor+1 clocks
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= div_reset;
      tick  <= 1'b0;
    end else if (div_load) begin
      count <= divisor;  // new rate starts from a full period
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= divisor;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            tick,
  input  logic                            tx_valid,
  input  logic [uart_pkg::data_width-1:0] tx_data,
  output logic                            tx_ready,
  output logic                            txd
);
  import uart_pkg::*;

  tx_state_t                 state;
  logic [data_cnt_width-1:0] cnt;       // upper bits pick the data bit
  logic [data_width-1:0]     tx_buf;
  logic                      accept;
  logic                      seg_end;   // last tick of start or stop bit
  logic                      data_end;  // last tick of bit 7

  assign tx_ready = (state == tx_idle);
  assign accept   = tx_valid && tx_ready;
  assign seg_end  = (cnt == data_cnt_width'(oversample - 1));
  assign data_end = (cnt == '1);

  // byte captured at the handshake
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_buf <= tx_data;
    end
  end

  // each tick drives the line level of the current state,
  // so a segment begins on the tick after the previous one ends
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= tx_idle;
      cnt   <= '0;
      txd   <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          txd <= 1'b1;
          cnt <= '0;
          if (accept) begin
            state <= tx_start;
          end
        end
        tx_start: begin
          if (tick) begin
            txd <= 1'b0;  // falls on first tick after accept
            if (seg_end) begin
              state <= uart_pkg::tx_data;  // scoped, port of the same name
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        uart_pkg::tx_data: begin
          if (tick) begin
            txd <= tx_buf[cnt[data_cnt_width-1:phase_width]];  // lsb first
            if (data_end) begin
              state <= tx_stop;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        tx_stop: begin
          if (tick) begin
            txd <= 1'b1;
            cnt <= cnt + 1'b1;
            if (seg_end) begin
              state <= tx_idle;  // ready again, next start waits a tick
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                tick,
  input  logic                rxd,
  output logic                rx_valid,
  output uart_pkg::rx_byte_t  rx_byte
);
  import uart_pkg::*;

  rx_state_t                state;
  logic                     rxd_meta;
  logic                     rxd_sync;
  logic                     rxd_prev;  // for edge detect
  logic [phase_width-1:0]   phase;
  logic [bit_idx_width-1:0] bit_idx;
  logic [data_width-1:0]    shreg;
  logic                     frame_err;
  logic                     fall;
  logic                     mid_start;
  logic                     sample_data;
  logic                     sample_stop;

  // two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall        = rxd_prev && !rxd_sync;
  assign mid_start   = tick && (state == rx_start) &&
                       (phase == phase_width'(oversample / 2 - 1));  // tick 8
  assign sample_data = tick && (state == rx_data) && (phase == '1);
  assign sample_stop = tick && (state == rx_stop) && (phase == '1);

  always_ff @(posedge clk) begin
    if (sample_data) begin
      shreg <= {rxd_sync, shreg[data_width-1:1]};  // lsb arrives first
    end
    if (sample_stop) begin
      frame_err <= !rxd_sync;
    end
  end

  assign rx_byte = '{data: shreg, frame_err: frame_err};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= rx_idle;
      phase    <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        rx_idle: begin
          phase   <= '0;
          bit_idx <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (mid_start) begin
            phase <= '0;
            // high at mid-start is a glitch
            state <= rxd_sync ? rx_idle : rx_data;
          end else if (tick) begin
            phase <= phase + 1'b1;
          end
        end
        rx_data: begin
          if (tick) begin
            phase <= phase + 1'b1;  // wraps after the 16th tick
          end
          if (sample_data) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == '1) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (sample_stop) begin
            rx_valid <= 1'b1;  // mid stop bit
            state    <= rx_idle;
          end else if (tick) begin
            phase <= phase + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic                            clk,
  input  logic                            reset,
  input  uart_pkg::cfg_cmd_t              cfg_cmd,
  output logic [uart_pkg::div_width-1:0]  cfg_rdata,
  input  logic                            tx_valid,
  input  logic [uart_pkg::data_width-1:0] tx_data,
  output logic                            tx_ready,
  output logic                            txd,
  input  logic                            rxd,
  output logic                            rx_valid,
  output uart_pkg::rx_byte_t              rx_byte
);
  import uart_pkg::*;

  cfg_t cfg;
  logic div_load;
  logic tick;
  logic rx_in;

  assign rx_in = cfg.loopback ? txd : rxd;  // loopback mux

  uart_cfg_regs u_cfg (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cfg_cmd),
    .rdata    (cfg_rdata),
    .cfg      (cfg),
    .div_load (div_load)
  );

  uart_baud_gen u_baud (
    .clk      (clk),
    .reset    (reset),
    .divisor  (cfg.divisor),
    .div_load (div_load),
    .tick     (tick)
  );

  uart_tx u_tx (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

  uart_rx u_rx (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .rxd      (rx_in),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

endmodule

`default_nettype wire

/* verif/uart_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_asserts (
  input logic                            clk,
  input logic                            reset,
  input logic                            tick,
  input logic                            tx_valid,
  input logic [uart_pkg::data_width-1:0] tx_data,
  input logic                            tx_ready,
  input logic                            txd,
  input logic [uart_pkg::div_width-1:0]  divisor
);

  // idle transmitter holds the line high
  a_idle_line: assert property (@(posedge clk) disable iff (reset)
    tx_ready |-> txd)
    else $error("txd low while the transmitter is idle");

  a_data_hold: assert property (@(posedge clk) disable iff (reset)
    (tx_valid && !tx_ready) |=> $stable(tx_data))
    else $error("tx_data changed while waiting for tx_ready");

  a_tick_width: assert property (@(posedge clk) disable iff (reset)
    (tick && divisor != '0) |=> !tick)  // single-cycle pulse
    else $error("tick high for two cycles with a nonzero divisor");

endmodule

bind uart_top uart_asserts i_asserts (
  .clk      (clk),
  .reset    (reset),
  .tick     (tick),
  .tx_valid (tx_valid),
  .tx_data  (tx_data),
  .tx_ready (tx_ready),
  .txd      (txd),
  .divisor  (cfg.divisor)
);

`default_nettype wire

/* verif/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
  import uart_pkg::*;

  localparam int n_loop      = 40;
  localparam int n_timing    = 6;
  localparam int n_bp        = 8;
  localparam int n_frame     = 12;
  localparam int max_div     = 7;  // largest random divisor
  localparam int n_chars     = n_loop + n_timing + n_bp + n_frame;
  localparam int cycle_limit = n_chars * 10 * oversample * (max_div + 1) * 2;

  logic                  clk;
  logic                  reset;
  cfg_cmd_t              cfg_cmd;
  logic [div_width-1:0]  cfg_rdata;
  logic                  tx_valid;
  logic [data_width-1:0] tx_data;
  logic                  tx_ready;
  logic                  txd;
  logic                  rxd;
  logic                  rx_valid;
  rx_byte_t              rx_byte;

  rx_byte_t exp_q[$];  // characters still expected at the receiver
  rx_byte_t exp_byte;
  string    test_name;
  int       cur_div;
  int       rx_count;
  int       cycles;

  uart_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .cfg_cmd   (cfg_cmd),
    .cfg_rdata (cfg_rdata),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_ready  (tx_ready),
    .txd       (txd),
    .rxd       (rxd),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run length bound of twice the slowest possible traffic
  initial begin
    cycles = 0;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Verification failed");
    $fatal(1);
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic expect_byte(input logic [7:0] d, input logic err);
    rx_byte_t b;
    b.data      = d;
    b.frame_err = err;
    exp_q.push_back(b);
  endtask

  task automatic write_reg(input cfg_addr_t addr, input logic [15:0] value);
    cfg_cmd.valid = 1'b1;
    cfg_cmd.write = 1'b1;
    cfg_cmd.addr  = addr;
    cfg_cmd.wdata = value;
    @(negedge clk);
    cfg_cmd.valid = 1'b0;
  endtask

  task automatic read_reg(input cfg_addr_t addr, output logic [15:0] value);
    cfg_cmd.valid = 1'b1;
    cfg_cmd.write = 1'b0;
    cfg_cmd.addr  = addr;
    @(negedge clk);
    cfg_cmd.valid = 1'b0;
    value = cfg_rdata;  // one edge after the command
  endtask

  // offer a byte and hold it until the handshake edge has passed
  task automatic send_byte(input logic [7:0] d);
    tx_valid = 1'b1;
    tx_data  = d;
    while (!tx_ready) @(negedge clk);
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  // 8N1 frame on rxd with a bit time of 16 x (divisor+1) clocks
  task automatic drive_frame(input logic [7:0] d, input logic stop);
    int bit_clks;
    bit_clks = oversample * (cur_div + 1);
    rxd = 1'b0;
    repeat (bit_clks) @(negedge clk);
    for (int i = 0; i < data_width; i++) begin
      rxd = d[i];
      repeat (bit_clks) @(negedge clk);
    end
    rxd = stop;
    repeat (bit_clks) @(negedge clk);
    rxd = 1'b1;  // one idle bit so the next start edge is seen
    repeat (bit_clks) @(negedge clk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic set_divisor(input int value);
    cur_div = value;
    write_reg(cfg_div, 16'(value));
  endtask

  // receive side checked against the queue head
  always @(negedge clk) begin
    if (!reset && rx_valid) begin
      if (exp_q.size() == 0) begin
        $display("receiver delivered a character that was never sent");
        $display("Verification failed");
        $fatal(1);
      end else begin
        exp_byte = exp_q.pop_front();
        rx_count++;
        check({test_name, " data"}, 32'(exp_byte.data), 32'(rx_byte.data));
        check({test_name, " frame_err"}, 32'(exp_byte.frame_err), 32'(rx_byte.frame_err));
      end
    end
  end

  initial begin
    logic [31:0]   r;
    logic [15:0]   rd;
    logic [7:0]    d;
    int            busy;
    int            bit_clks;

    void'($urandom(4));
    reset     = 1'b1;
    cfg_cmd   = '0;
    tx_valid  = 1'b0;
    tx_data   = '0;
    rxd       = 1'b1;
    rx_count  = 0;
    cur_div   = int'(div_reset);
    test_name = "reset";
    repeat (4) @(negedge clk);
    reset = 1'b0;

    check("reset txd", 32'd1, 32'(txd));
    check("reset tx_ready", 32'd1, 32'(tx_ready));
    check("reset rx_valid", 32'd0, 32'(rx_valid));
    read_reg(cfg_div, rd);
    check("reset divisor", 32'(div_reset), 32'(rd));

    test_name = "readback";
    repeat (4) begin
      r = $urandom;
      write_reg(cfg_div, r[15:0]);
      write_reg(cfg_ctrl, r[31:16]);
      read_reg(cfg_div, rd);
      check("readback divisor", 32'(r[15:0]), 32'(rd));
      read_reg(cfg_ctrl, rd);
      check("readback loopback", 32'(r[16]), 32'(rd));  // only bit 0 is kept
    end
    set_divisor(int'(div_reset));
    write_reg(cfg_ctrl, 16'd1);

    test_name = "loopback";
    for (int i = 0; i < n_loop; i++) begin
      r = $urandom;
      d = r[7:0];
      expect_byte(d, 1'b0);
      send_byte(d);
      repeat (int'(r[12:8])) @(negedge clk);  // random gap
    end
    wait_drain();

    test_name = "bit timing";
    for (int i = 0; i < n_timing; i++) begin
      set_divisor(int'($urandom_range(max_div, 1)));
      r = $urandom;
      d = r[7:0] | 8'h01;  // data bit 0 high, so its start shows as a rising edge
      expect_byte(d, 1'b0);
      fork
        send_byte(d);
        begin
          while (txd) @(negedge clk);
          bit_clks = 0;
          while (!txd) begin
            @(negedge clk);
            bit_clks++;
          end
          check("bit timing start bit clocks", 32'(oversample * (cur_div + 1)),
                32'(bit_clks));
        end
      join
      wait_drain();
    end

    test_name = "back-pressure";
    set_divisor(int'($urandom_range(max_div, 1)));
    tx_valid = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      r = $urandom;
      d = r[7:0];
      tx_data = d;
      expect_byte(d, 1'b0);
      busy = 0;
      while (!tx_ready) begin
        @(negedge clk);
        busy++;
      end
      // 160 ticks per frame and the first one comes up to a tick period after accept
      if (i > 0) begin
        check("back-pressure busy window", 32'd1,
              32'(busy >= (oversample * 10 - 1) * (cur_div + 1) + 1 &&
                  busy <= oversample * 10 * (cur_div + 1)));
      end
      @(negedge clk);
    end
    tx_valid = 1'b0;
    wait_drain();

    test_name = "framing";
    write_reg(cfg_ctrl, 16'd0);
    set_divisor(int'($urandom_range(max_div, 1)));
    for (int i = 0; i < n_frame; i++) begin
      r = $urandom;
      d = r[7:0];
      expect_byte(d, !r[8]);
      drive_frame(d, r[8]);
    end
    wait_drain();

    check("received character count", 32'(n_chars), 32'(rx_count));
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/uart_pkg.sv
src/uart_cfg_regs.sv
src/uart_baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verif/uart_asserts.sv
verif/uart_tb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = uart_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Verification failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
